//--- include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

////////////////////
// cache geometry
////////////////////

// set index bits, 16 sets
`define DCACHE_INDEX_WIDTH 4

// word-in-line bits, four words per line
`define DCACHE_OFFSET_WIDTH 2

////////////////////
// bus widths
////////////////////

// byte address
`define DCACHE_ADDR_WIDTH 32

`endif

//--- src/bus_pkg.sv
`default_nettype none

`include "dcache_cfg.svh"

package bus_pkg;

    // byte address on both buses
    typedef logic [`DCACHE_ADDR_WIDTH-1:0] addr_t;

    typedef logic [31:0] word_t;

    // one enable per byte lane
    typedef logic [3:0] strb_t;

    // whole line, as delivered in one refill beat
    typedef logic [32*(1 << `DCACHE_OFFSET_WIDTH)-1:0] line_t;

endpackage

`default_nettype wire

//--- src/dcache_pkg.sv
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    ////////////////////
    // address fields
    ////////////////////

    typedef logic [`DCACHE_INDEX_WIDTH-1:0] index_t;

    // word within a line
    typedef logic [`DCACHE_OFFSET_WIDTH-1:0] offset_t;

    // what is left above index, offset and the two byte bits
    typedef logic [`DCACHE_ADDR_WIDTH-`DCACHE_INDEX_WIDTH-`DCACHE_OFFSET_WIDTH-3:0] tag_t;

    ////////////////////
    // controller FSM
    ////////////////////

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        refill,
        write_req,
        write_wait,
        respond
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/dcache_rbuf.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_rbuf (
    input  logic          clk,
    input  logic          arst_n,

    input  logic          load,

    input  logic          write_in,
    input  bus_pkg::addr_t addr_in,
    input  bus_pkg::word_t wdata_in,
    input  bus_pkg::strb_t wstrb_in,

    output logic          write_q,
    output bus_pkg::addr_t addr_q,
    output bus_pkg::word_t wdata_q,
    output bus_pkg::strb_t wstrb_q
);

    // kind and address steer the controller, so they come out of reset
    // as a plain read of address zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_q <= 1'b0;
            addr_q  <= '0;
        end else if (load) begin
            write_q <= write_in;
            addr_q  <= addr_in;
        end
    end

    // store payload
    always_ff @(posedge clk) begin
        if (load) begin
            wdata_q <= wdata_in;
            wstrb_q <= wstrb_in;
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_tagv.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tagv (
    input  logic               clk,
    input  logic               arst_n,

    input  dcache_pkg::index_t rd_index,
    input  dcache_pkg::tag_t   cmp_tag,
    output logic [1:0]         hit,

    input  dcache_pkg::index_t wr_index,
    input  logic [1:0]         we,

    input  logic               lru_touch,
    input  logic               lru_way_used,
    output logic               victim
);

    localparam int sets = 1 << `DCACHE_INDEX_WIDTH;

    dcache_pkg::tag_t       tag_mem [2][sets];
    logic [1:0][sets-1:0]   valid;
    logic [sets-1:0]        lru;

    dcache_pkg::tag_t       tag_q [2];
    logic [1:0]             valid_q;

    ////////////////////
    // valid and LRU state
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= '0;
            valid_q <= '0;
            lru     <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we[w])
                    valid[w][wr_index] <= 1'b1;
                valid_q[w] <= valid[w][rd_index];
            end
            // lru bit holds the way to evict next
            if (lru_touch)
                lru[wr_index] <= ~lru_way_used;
        end
    end

    ////////////////////
    // tag storage
    ////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we[w])
                tag_mem[w][wr_index] <= cmp_tag;
            tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    // compare against the buffered tag during lookup
    always_comb begin
        for (int w = 0; w < 2; w++)
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
    end

    assign victim = lru[wr_index];

endmodule

`default_nettype wire

//--- src/dcache_data.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache_data (
    input  logic                clk,

    input  dcache_pkg::index_t  rd_index,
    output bus_pkg::line_t      line0,
    output bus_pkg::line_t      line1,

    input  dcache_pkg::index_t  wr_index,
    input  dcache_pkg::offset_t wr_offset,
    input  bus_pkg::line_t      refill_line,
    input  bus_pkg::word_t      store_word,
    input  bus_pkg::strb_t      store_strb,
    input  logic [1:0]          we,
    input  logic                refill
);

    localparam int sets = 1 << `DCACHE_INDEX_WIDTH;
    localparam int lanes = $bits(bus_pkg::strb_t);

    bus_pkg::line_t lines [2][sets];

    ////////////////////
    // line writes
    ////////////////////

    // refill replaces the line, a store hit only touches its own bytes
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we[w]) begin
                if (refill) begin
                    lines[w][wr_index] <= refill_line;
                end else begin
                    for (int b = 0; b < lanes; b++) begin
                        if (store_strb[b])
                            lines[w][wr_index][32*wr_offset + 8*b +: 8] <=
                                store_word[8*b +: 8];
                    end
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // registered, so the accept cycle's index gives data in lookup
    always_ff @(posedge clk) begin
        line0 <= lines[0][rd_index];
        line1 <= lines[1][rd_index];
    end

endmodule

`default_nettype wire

//--- src/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
    input  logic       clk,
    input  logic       arst_n,

    // pipeline handshake
    input  logic       req_valid,
    output logic       req_ready,

    // lookup results
    input  logic       write_q,
    input  logic [1:0] hit,
    input  logic       victim,

    // buffer and array control
    output logic       rbuf_load,
    output logic [1:0] tagv_we,
    output logic [1:0] data_we,
    output logic       data_refill,
    output logic       lru_touch,
    output logic       lru_way_used,

    // response steering
    output logic       resp_from_refill,
    output logic       resp_way,
    output logic       rdata_valid,

    // memory bus
    output logic       mem_req,
    output logic       mem_write,
    input  logic       mem_addr_ok,
    input  logic       mem_data_ok,
    input  logic       mem_bvalid
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_nxt;

    logic       lookup_hit;
    logic       read_hit;
    logic       store_hit;
    logic       refill_done;
    logic [1:0] victim_sel;

    assign lookup_hit  = (state == dcache_pkg::lookup) && (|hit);
    assign read_hit    = lookup_hit && !write_q;
    assign store_hit   = lookup_hit && write_q;
    assign refill_done = (state == dcache_pkg::refill) && mem_data_ok;
    assign victim_sel  = {victim, ~victim};

    ////////////////////
    // handshake
    ////////////////////

    // a read hit frees the buffer in the same cycle it answers
    assign req_ready = (state == dcache_pkg::idle) || read_hit;
    assign rbuf_load = req_valid && req_ready;

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::idle: begin
                if (req_valid)
                    state_nxt = dcache_pkg::lookup;
            end
            dcache_pkg::lookup: begin
                // every store goes to memory, hit or miss
                if (write_q)
                    state_nxt = dcache_pkg::write_req;
                else if (|hit)
                    state_nxt = req_valid ? dcache_pkg::lookup : dcache_pkg::idle;
                else
                    state_nxt = dcache_pkg::miss_req;
            end
            dcache_pkg::miss_req: begin
                if (mem_addr_ok)
                    state_nxt = dcache_pkg::refill;
            end
            dcache_pkg::refill: begin
                if (mem_data_ok)
                    state_nxt = dcache_pkg::respond;
            end
            dcache_pkg::write_req: begin
                if (mem_addr_ok)
                    state_nxt = dcache_pkg::write_wait;
            end
            dcache_pkg::write_wait: begin
                if (mem_bvalid)
                    state_nxt = dcache_pkg::idle;
            end
            dcache_pkg::respond: begin
                state_nxt = dcache_pkg::idle;
            end
            default: begin
                state_nxt = dcache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= dcache_pkg::idle;
            rdata_valid <= 1'b0;
        end else begin
            state       <= state_nxt;
            // pulse lands one cycle after the hit or the refill beat
            rdata_valid <= read_hit || refill_done;
        end
    end

    ////////////////////
    // array writes
    ////////////////////

    assign tagv_we      = refill_done ? victim_sel : 2'b00;
    assign data_we      = refill_done ? victim_sel : (store_hit ? hit : 2'b00);
    assign data_refill  = (state == dcache_pkg::refill);
    assign lru_touch    = refill_done || lookup_hit;
    assign lru_way_used = refill_done ? victim : hit[1];

    assign resp_from_refill = (state == dcache_pkg::refill);
    assign resp_way         = hit[1];

    // memory request held until the address is taken
    assign mem_req   = (state == dcache_pkg::miss_req) || (state == dcache_pkg::write_req);
    assign mem_write = (state == dcache_pkg::write_req);

endmodule

`default_nettype wire

//--- src/dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module dcache (
    input  logic           clk,
    input  logic           arst_n,

    // pipeline side
    input  logic           req_valid,
    input  logic           req_write,
    input  bus_pkg::addr_t req_addr,
    input  bus_pkg::word_t req_wdata,
    input  bus_pkg::strb_t req_wstrb,
    output logic           req_ready,
    output bus_pkg::word_t rdata,
    output logic           rdata_valid,

    // memory side
    output logic           mem_req,
    output logic           mem_write,
    output bus_pkg::addr_t mem_addr,
    output bus_pkg::word_t mem_wdata,
    output bus_pkg::strb_t mem_wstrb,
    input  logic           mem_addr_ok,
    input  logic           mem_data_ok,
    input  logic           mem_bvalid,
    input  bus_pkg::line_t mem_rline
);

    localparam int off_lo = 2;
    localparam int idx_lo = off_lo + `DCACHE_OFFSET_WIDTH;
    localparam int tag_lo = idx_lo + `DCACHE_INDEX_WIDTH;

    logic                rbuf_load;
    logic                write_q;
    bus_pkg::addr_t      addr_q;
    bus_pkg::word_t      wdata_q;
    bus_pkg::strb_t      wstrb_q;

    dcache_pkg::index_t  req_index;
    dcache_pkg::index_t  buf_index;
    dcache_pkg::offset_t buf_offset;
    dcache_pkg::tag_t    buf_tag;

    logic [1:0]          hit;
    logic                victim;
    logic [1:0]          tagv_we;
    logic [1:0]          data_we;
    logic                data_refill;
    logic                lru_touch;
    logic                lru_way_used;
    logic                resp_from_refill;
    logic                resp_way;

    bus_pkg::line_t      line0;
    bus_pkg::line_t      line1;
    bus_pkg::line_t      resp_line;

    // incoming index feeds the array reads, buffered fields do the rest
    assign req_index  = req_addr[idx_lo +: `DCACHE_INDEX_WIDTH];
    assign buf_index  = addr_q[idx_lo +: `DCACHE_INDEX_WIDTH];
    assign buf_offset = addr_q[off_lo +: `DCACHE_OFFSET_WIDTH];
    assign buf_tag    = addr_q[`DCACHE_ADDR_WIDTH-1:tag_lo];

    dcache_rbuf rbuf_i (
        .clk(clk), .arst_n(arst_n), .load(rbuf_load),
        .write_in(req_write), .addr_in(req_addr),
        .wdata_in(req_wdata), .wstrb_in(req_wstrb),
        .write_q(write_q), .addr_q(addr_q),
        .wdata_q(wdata_q), .wstrb_q(wstrb_q)
    );

    dcache_tagv tagv_i (
        .clk(clk), .arst_n(arst_n),
        .rd_index(req_index), .cmp_tag(buf_tag), .hit(hit),
        .wr_index(buf_index), .we(tagv_we),
        .lru_touch(lru_touch), .lru_way_used(lru_way_used), .victim(victim)
    );

    dcache_data data_i (
        .clk(clk),
        .rd_index(req_index), .line0(line0), .line1(line1),
        .wr_index(buf_index), .wr_offset(buf_offset),
        .refill_line(mem_rline), .store_word(wdata_q), .store_strb(wstrb_q),
        .we(data_we), .refill(data_refill)
    );

    dcache_ctrl ctrl_i (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready(req_ready),
        .write_q(write_q), .hit(hit), .victim(victim),
        .rbuf_load(rbuf_load), .tagv_we(tagv_we), .data_we(data_we),
        .data_refill(data_refill), .lru_touch(lru_touch), .lru_way_used(lru_way_used),
        .resp_from_refill(resp_from_refill), .resp_way(resp_way),
        .rdata_valid(rdata_valid),
        .mem_req(mem_req), .mem_write(mem_write),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_bvalid(mem_bvalid)
    );

    ////////////////////
    // response word
    ////////////////////

    always_comb begin
        if (resp_from_refill)
            resp_line = mem_rline;
        else
            resp_line = resp_way ? line1 : line0;
    end

    // captured every cycle, only meaningful alongside rdata_valid
    always_ff @(posedge clk) begin
        rdata <= resp_line[32*buf_offset +: 32];
    end

    // refill reads are line aligned, stores carry the full address
    assign mem_addr  = mem_write ? addr_q : {addr_q[`DCACHE_ADDR_WIDTH-1:idx_lo], {idx_lo{1'b0}}};
    assign mem_wdata = wdata_q;
    assign mem_wstrb = mem_write ? wstrb_q : '0;

endmodule

`default_nettype wire

//--- testbench/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache;

    localparam int clk_period    = 100;
    localparam int reset_cycles  = 16;
    localparam int max_access    = 64;
    localparam int mem_addr_bits = 12;
    localparam int mem_words     = 1 << mem_addr_bits;
    localparam int sets          = 1 << `DCACHE_INDEX_WIDTH;
    localparam int line_words    = 1 << `DCACHE_OFFSET_WIDTH;
    localparam int idx_lo        = 2 + `DCACHE_OFFSET_WIDTH;
    localparam int tag_lo        = idx_lo + `DCACHE_INDEX_WIDTH;

    logic           clk;
    logic           arst_n;
    logic           req_valid;
    logic           req_write;
    bus_pkg::addr_t req_addr;
    bus_pkg::word_t req_wdata;
    bus_pkg::strb_t req_wstrb;
    logic           req_ready;
    bus_pkg::word_t rdata;
    logic           rdata_valid;
    logic           mem_req;
    logic           mem_write;
    bus_pkg::addr_t mem_addr;
    bus_pkg::word_t mem_wdata;
    bus_pkg::strb_t mem_wstrb;
    logic           mem_addr_ok;
    logic           mem_data_ok;
    logic           mem_bvalid;
    bus_pkg::line_t mem_rline;

    // accesses from the data file
    logic           acc_kind [max_access];
    bus_pkg::addr_t acc_addr [max_access];
    bus_pkg::word_t acc_wdata [max_access];
    bus_pkg::strb_t acc_strb [max_access];
    bus_pkg::word_t acc_exp [max_access];
    int             n_access;

    bus_pkg::word_t mem_model [mem_words];
    int             reads_total;
    int             writes_total;
    bus_pkg::addr_t last_rd_addr;
    bus_pkg::addr_t last_wr_addr;
    bus_pkg::word_t last_wr_data;
    bus_pkg::strb_t last_wr_strb;

    // shadow of the cache directory
    dcache_pkg::tag_t sh_tag [2][sets];
    logic             sh_valid [2][sets];
    logic             sh_lru [sets];

    int errors;
    int watchdog_cycles;

    dcache dut_i (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb), .req_ready(req_ready),
        .rdata(rdata), .rdata_valid(rdata_valid),
        .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .mem_bvalid(mem_bvalid), .mem_rline(mem_rline)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic int word_index(input bus_pkg::addr_t a);
        return int'(a[2 +: mem_addr_bits]);
    endfunction

    function automatic bus_pkg::word_t merge_bytes(input bus_pkg::word_t old_w,
                                                   input bus_pkg::word_t new_w,
                                                   input bus_pkg::strb_t strb);
        bus_pkg::word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    // way holding the address in the shadow or -1 when absent
    function automatic int resident_way(input bus_pkg::addr_t a);
        dcache_pkg::index_t s;
        dcache_pkg::tag_t   t;
        s = a[idx_lo +: `DCACHE_INDEX_WIDTH];
        t = a[`DCACHE_ADDR_WIDTH-1:tag_lo];
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[w][s] && sh_tag[w][s] == t)
                return w;
        end
        return -1;
    endfunction

    task automatic wait_falling(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic load_testdata();
        int             fd;
        int             code;
        string          line;
        logic [3:0]     f_kind;
        bus_pkg::addr_t f_addr;
        bus_pkg::word_t f_wdata;
        bus_pkg::strb_t f_strb;
        bus_pkg::word_t f_exp;
        fd = $fopen("testbench/dcache_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open testbench/dcache_testdata.txt");
            return;
        end
        while ($fgets(line, fd) != 0 && n_access < max_access) begin
            // 8'h23 is '#' and marks a comment line
            if (line.len() < 2 || line.getc(0) == 8'h23)
                continue;
            code = $sscanf(line, "%h %h %h %h %h", f_kind, f_addr, f_wdata, f_strb, f_exp);
            if (code != 5 || f_kind > 4'd1 || f_addr >= 32'(mem_words * 4)) begin
                errors++;
                $display("bad line in test data: %s", line);
                continue;
            end
            acc_kind[n_access]  = f_kind[0];
            acc_addr[n_access]  = f_addr;
            acc_wdata[n_access] = f_wdata;
            acc_strb[n_access]  = f_strb;
            acc_exp[n_access]   = f_exp;
            n_access++;
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        if (!req_ready)
            flag_error("req_ready low after reset");
        if (mem_req)
            flag_error("mem_req high after reset");
        if (rdata_valid)
            flag_error("rdata_valid high after reset");
    endtask

    ////////////////////
    // one access
    ////////////////////

    task automatic run_access(input int i);
        int                 way;
        int                 lat;
        int                 rd_before;
        int                 wr_before;
        logic               v;
        dcache_pkg::index_t s;
        dcache_pkg::tag_t   t;
        bus_pkg::addr_t     line_base;
        bus_pkg::word_t     model_word;

        way = resident_way(acc_addr[i]);
        s = acc_addr[i][idx_lo +: `DCACHE_INDEX_WIDTH];
        t = acc_addr[i][`DCACHE_ADDR_WIDTH-1:tag_lo];
        line_base = acc_addr[i];
        line_base[idx_lo-1:0] = '0;
        model_word = mem_model[word_index(acc_addr[i])];

        while (!req_ready)
            @(negedge clk);
        rd_before = reads_total;
        wr_before = writes_total;
        req_valid = 1'b1;
        req_write = acc_kind[i];
        req_addr  = acc_addr[i];
        req_wdata = acc_wdata[i];
        req_wstrb = acc_strb[i];
        @(posedge clk);
        @(negedge clk);
        // inputs move on while the cache keeps its own copy
        req_valid = 1'b0;
        req_write = ~acc_kind[i];
        req_addr  = ~acc_addr[i];
        req_wdata = ~acc_wdata[i];
        req_wstrb = ~acc_strb[i];
        if (rdata_valid)
            flag_error($sformatf("access %0d response pulse in lookup", i));

        if (!acc_kind[i]) begin
            // ready stays high in lookup only for a read hit
            if (way >= 0 && !req_ready)
                flag_error($sformatf("access %0d req_ready low in read hit lookup", i));
            if (way < 0 && req_ready)
                flag_error($sformatf("access %0d req_ready high in read miss lookup", i));
            lat = 1;
            @(negedge clk);
            while (!rdata_valid) begin
                @(negedge clk);
                lat++;
            end
            if (rdata !== acc_exp[i])
                flag_error($sformatf("access %0d read %h at %h, expected %h",
                                     i, rdata, acc_addr[i], acc_exp[i]));
            if (acc_exp[i] !== model_word)
                flag_error($sformatf("access %0d test data expects %h, memory holds %h",
                                     i, acc_exp[i], model_word));
            if (way >= 0) begin
                if (lat != 1)
                    flag_error($sformatf("access %0d hit latency %0d, expected 1", i, lat));
                if (reads_total != rd_before || writes_total != wr_before)
                    flag_error($sformatf("access %0d hit caused memory traffic", i));
                sh_lru[s] = (way == 0);
            end else begin
                if (reads_total - rd_before != 1 || writes_total != wr_before)
                    flag_error($sformatf("access %0d miss gave %0d reads, %0d writes",
                                         i, reads_total - rd_before, writes_total - wr_before));
                if (last_rd_addr !== line_base)
                    flag_error($sformatf("access %0d refill address %h, expected %h",
                                         i, last_rd_addr, line_base));
                // refill goes to the LRU way
                v = sh_lru[s];
                sh_tag[v][s]   = t;
                sh_valid[v][s] = 1'b1;
                sh_lru[s]      = ~v;
            end
            @(negedge clk);
            if (rdata_valid)
                flag_error($sformatf("access %0d rdata_valid longer than one cycle", i));
        end else begin
            if (req_ready)
                flag_error($sformatf("access %0d req_ready high in store lookup", i));
            while (!req_ready) begin
                @(negedge clk);
                if (rdata_valid)
                    flag_error($sformatf("access %0d response pulse for a store", i));
            end
            if (writes_total - wr_before != 1 || reads_total != rd_before)
                flag_error($sformatf("access %0d store gave %0d writes, %0d reads",
                                     i, writes_total - wr_before, reads_total - rd_before));
            if (last_wr_addr !== acc_addr[i] || last_wr_data !== acc_wdata[i] ||
                last_wr_strb !== acc_strb[i])
                flag_error($sformatf("access %0d write %h/%h/%h, expected %h/%h/%h",
                                     i, last_wr_addr, last_wr_data, last_wr_strb,
                                     acc_addr[i], acc_wdata[i], acc_strb[i]));
            // no allocate so a hit only refreshes the LRU bit
            if (way >= 0)
                sh_lru[s] = (way == 0);
        end
    endtask

    ////////////////////
    // memory model
    ////////////////////

    initial begin : mem_model_proc
        int             d;
        int             base;
        logic           w;
        bus_pkg::addr_t a;
        bus_pkg::word_t wd;
        bus_pkg::strb_t ws;
        mem_addr_ok  = 1'b0;
        mem_data_ok  = 1'b0;
        mem_bvalid   = 1'b0;
        mem_rline    = '0;
        reads_total  = 0;
        writes_total = 0;
        for (int i = 0; i < mem_words; i++)
            mem_model[i] = 32'(i) ^ 32'h5a5a0000;
        void'($urandom(32'hc19e6fc5));
        forever begin
            @(negedge clk);
            if (mem_req) begin
                d = int'($urandom % 4);
                wait_falling(d);
                mem_addr_ok = 1'b1;
                a  = mem_addr;
                w  = mem_write;
                wd = mem_wdata;
                ws = mem_wstrb;
                if (w) begin
                    writes_total++;
                    last_wr_addr = a;
                    last_wr_data = wd;
                    last_wr_strb = ws;
                end else begin
                    reads_total++;
                    last_rd_addr = a;
                end
                @(negedge clk);
                mem_addr_ok = 1'b0;
                d = int'($urandom % 4);
                wait_falling(d);
                if (w) begin
                    mem_model[word_index(a)] = merge_bytes(mem_model[word_index(a)], wd, ws);
                    mem_bvalid = 1'b1;
                end else begin
                    base = word_index(a);
                    for (int k = 0; k < line_words; k++)
                        mem_rline[32*k +: 32] = mem_model[base + k];
                    mem_data_ok = 1'b1;
                end
                @(negedge clk);
                mem_bvalid  = 1'b0;
                mem_data_ok = 1'b0;
                mem_rline   = '0;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not end within %0d cycles", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin : main_seq
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        errors    = 0;
        n_access  = 0;
        watchdog_cycles = 0;
        for (int s = 0; s < sets; s++) begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                sh_valid[w][s] = 1'b0;
                sh_tag[w][s]   = '0;
            end
        end

        load_testdata();
        if (n_access == 0)
            flag_error("no accesses in the test data");
        watchdog_cycles = n_access * 20 + reset_cycles;

        wait_falling(reset_cycles);
        arst_n = 1'b1;
        check_reset_state();
        for (int i = 0; i < n_access; i++)
            run_access(i);

        $display("tb_dcache: %0d accesses, %0d errors", n_access, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/bus_pkg.sv
src/dcache_pkg.sv
src/dcache_rbuf.sv
src/dcache_tagv.sv
src/dcache_data.sv
src/dcache_ctrl.sv
src/dcache.sv
testbench/tb_dcache.sv

//--- Makefile
# Verilator build and run of the data cache testbench

TOP  = tb_dcache
MDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir $(MDIR) -o $(TOP)

run: build
	./$(MDIR)/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf $(MDIR) sim.log

//--- testbench/dcache_testdata.txt
# kind addr wdata strb expected, all fields in hex
# kind 0 is a read, 1 is a store; expected is unused for stores
0 00000100 00000000 0 5a5a0040
0 00000104 00000000 0 5a5a0041
0 0000020c 00000000 0 5a5a0083
0 00000108 00000000 0 5a5a0042
0 00000300 00000000 0 5a5a00c0
0 00000200 00000000 0 5a5a0080
1 00000304 a1b2c3d4 3 00000000
0 00000304 00000000 0 5a5ac3d4
1 00000424 11223344 c 00000000
0 00000424 00000000 0 11220109
0 00000420 00000000 0 5a5a0108
1 00000428 deadbeef f 00000000
0 00000428 00000000 0 deadbeef
1 00000f3c 000000ff 1 00000000
0 00000f3c 00000000 0 5a5a03ff
0 00000f30 00000000 0 5a5a03cc
0 00000000 00000000 0 5a5a0000
0 00000308 00000000 0 5a5a00c2
0 00000204 00000000 0 5a5a0081
0 00000304 00000000 0 5a5ac3d4
